/* common/exCorePkg.sv */
package exCorePkg;

    // ==========================================================================
    // Basic widths
    // ==========================================================================

    // Data, address and instruction word
    typedef logic [31:0] tWord;

    // Architectural register index, x0..x31
    typedef logic [4:0] tRegIdx;

    // Minor opcode fields
    typedef logic [2:0] tFunct3;
    typedef logic [6:0] tFunct7;

    // ==========================================================================
    // Encodings
    // ==========================================================================

    // RV32I major opcodes of the supported subset
    typedef enum logic [6:0] {
        R_OP   = 7'b0110011,
        I_OP   = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } tOpcode;

    // ALU operations, PASSB hands operand 2 straight through (LUI)
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLL,
        SRL,
        PASSB
    } tAluOp;

    // ==========================================================================
    // Control bundles produced by the decoder
    // ==========================================================================

    typedef struct packed {
        tAluOp aluOp;
        logic  useImm;     // Operand 2 from the immediate
    } tCtrlAlu;

    // regWrEn is already low for rd == x0
    typedef struct packed {
        tRegIdx regSrc1;
        tRegIdx regSrc2;
        tRegIdx regDst;
        logic   regWrEn;
    } tCtrlRf;

    typedef struct packed {
        logic memRd;       // LW
        logic memWr;       // SW
        logic isBranch;
        logic branchNe;    // BNE when set, BEQ otherwise
        logic isJal;
    } tCtrlMem;

    // Trace records, shared with the testbench
    typedef struct packed {
        logic   valid;
        tRegIdx dst;
        tWord   data;
    } tWbTrace;

    typedef struct packed {
        logic valid;
        tWord addr;
        tWord data;
    } tStTrace;

endpackage

/* source/exCoreMem.sv */
`timescale 1ns/10ps

module exCoreMem #(
    parameter int ADDR_BITS = 8
) (
    input  logic            Clk,
    input  exCorePkg::tWord addr,
    input  logic            wrEn,
    input  exCorePkg::tWord wrData,
    output exCorePkg::tWord rdData
);
    import exCorePkg::*;

    // Word storage, one entry per 32-bit word
    tWord mem [2**ADDR_BITS];

    // Byte address in, word index out
    logic [ADDR_BITS-1:0] wordIdx;

    assign wordIdx = addr[ADDR_BITS+1:2];

    // Contents start out as zero
    initial begin
        for (int i = 0; i < 2**ADDR_BITS; i++) begin
            mem[i] = '0;
        end
    end

    // Read returns the old word, write lands on the same edge
    always_ff @(posedge Clk) begin
        rdData <= mem[wordIdx];
        if (wrEn) begin
            mem[wordIdx] <= wrData;
        end
    end

endmodule

/* decoder/exCoreDecoder.sv */
`timescale 1ns/10ps

module exCoreDecoder (
    input  exCorePkg::tWord    instruction,
    output exCorePkg::tOpcode  opcode,
    output exCorePkg::tWord    imm,
    output exCorePkg::tCtrlAlu ctrlAlu,
    output exCorePkg::tCtrlRf  ctrlRf,
    output exCorePkg::tCtrlMem ctrlMem
);
    import exCorePkg::*;

    // Instruction fields
    tRegIdx rd;
    tRegIdx rs1;
    tRegIdx rs2;
    tFunct3 funct3;
    tFunct7 funct7;

    // Sign-extended immediates, one per format
    tWord   immI;
    tWord   immS;
    tWord   immB;
    tWord   immU;
    tWord   immJ;

    // Instruction commits a register write (before the x0 check)
    logic   writesRd;

    assign opcode = tOpcode'(instruction[6:0]);
    assign rd     = instruction[11:7];
    assign funct3 = instruction[14:12];
    assign rs1    = instruction[19:15];
    assign rs2    = instruction[24:20];
    assign funct7 = instruction[31:25];

    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign immU = {instruction[31:12], 12'b0};
    assign immJ = {{11{instruction[31]}}, instruction[31], instruction[19:12],
                   instruction[20], instruction[30:21], 1'b0};

    // ==========================================================================
    // Control decode, anything unknown falls out as a no-op
    // ==========================================================================
    always_comb begin
        ctrlAlu  = '{aluOp: ADD, useImm: 1'b0};
        ctrlRf   = '{regSrc1: rs1, regSrc2: rs2, regDst: rd, regWrEn: 1'b0};
        ctrlMem  = '0;
        imm      = '0;
        writesRd = 1'b0;
        case (opcode)
            R_OP: begin
                writesRd = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: ctrlAlu.aluOp = ADD;
                    {7'h20, 3'b000}: ctrlAlu.aluOp = SUB;
                    {7'h00, 3'b111}: ctrlAlu.aluOp = AND;
                    {7'h00, 3'b110}: ctrlAlu.aluOp = OR;
                    {7'h00, 3'b100}: ctrlAlu.aluOp = XOR;
                    {7'h00, 3'b010}: ctrlAlu.aluOp = SLT;
                    {7'h00, 3'b001}: ctrlAlu.aluOp = SLL;
                    {7'h00, 3'b101}: ctrlAlu.aluOp = SRL;
                    default:         writesRd = 1'b0;
                endcase
            end
            I_OP: begin
                imm            = immI;
                ctrlAlu.useImm = 1'b1;
                writesRd       = 1'b1;
                case (funct3)
                    3'b000:  ctrlAlu.aluOp = ADD;
                    3'b111:  ctrlAlu.aluOp = AND;
                    3'b110:  ctrlAlu.aluOp = OR;
                    3'b100:  ctrlAlu.aluOp = XOR;
                    3'b010:  ctrlAlu.aluOp = SLT;
                    // Shift-immediates and SLTIU are not supported
                    default: writesRd = 1'b0;
                endcase
            end
            LUI: begin
                imm      = immU;
                ctrlAlu  = '{aluOp: PASSB, useImm: 1'b1};
                writesRd = 1'b1;
            end
            LOAD: begin
                // Word loads only
                if (funct3 == 3'b010) begin
                    imm           = immI;
                    ctrlAlu       = '{aluOp: ADD, useImm: 1'b1};
                    ctrlMem.memRd = 1'b1;
                    writesRd      = 1'b1;
                end
            end
            STORE: begin
                if (funct3 == 3'b010) begin
                    imm           = immS;
                    ctrlAlu       = '{aluOp: ADD, useImm: 1'b1};
                    ctrlMem.memWr = 1'b1;
                end
            end
            BRANCH: begin
                // BEQ and BNE, compared by subtraction
                if (funct3[2:1] == 2'b00) begin
                    imm              = immB;
                    ctrlAlu.aluOp    = SUB;
                    ctrlMem.isBranch = 1'b1;
                    ctrlMem.branchNe = funct3[0];
                end
            end
            JAL: begin
                imm           = immJ;
                ctrlMem.isJal = 1'b1;
                writesRd      = 1'b1;
            end
            default: begin
            end
        endcase
        // Writes to x0 are dropped right here
        ctrlRf.regWrEn = writesRd && (rd != '0);
    end

endmodule

/* source/exCoreRegFile.sv */
`timescale 1ns/10ps

module exCoreRegFile (
    input  logic              Clk,
    input  logic              reset,
    input  exCorePkg::tRegIdx rdIdx1,
    input  exCorePkg::tRegIdx rdIdx2,
    output exCorePkg::tWord   rdData1,
    output exCorePkg::tWord   rdData2,
    input  logic              wrEn,
    input  exCorePkg::tRegIdx wrIdx,
    input  exCorePkg::tWord   wrData
);
    import exCorePkg::*;

    // Architectural registers x0..x31
    tWord regs [32];

    // ==========================================================================
    // Write port
    // ==========================================================================
    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            // wrEn never comes with x0
            regs[wrIdx] <= wrData;
        end
    end

    // ==========================================================================
    // Read ports, no bypass of a write in the same cycle
    // ==========================================================================
    assign rdData1 = (rdIdx1 == '0) ? '0 : regs[rdIdx1];
    assign rdData2 = (rdIdx2 == '0) ? '0 : regs[rdIdx2];

endmodule

/* source/exCoreAlu.sv */
`timescale 1ns/10ps

module exCoreAlu (
    input  exCorePkg::tWord    operand1,
    input  exCorePkg::tWord    operand2,
    input  exCorePkg::tCtrlAlu ctrl,
    output exCorePkg::tWord    result,
    output logic               zero
);
    import exCorePkg::*;

    // Shift distance, low five bits only
    logic [4:0] shamt;

    // Signed compare for SLT
    logic       lessThan;

    assign shamt    = operand2[4:0];
    assign lessThan = $signed(operand1) < $signed(operand2);

    // ==========================================================================
    // Operation select
    // ==========================================================================
    always_comb begin
        case (ctrl.aluOp)
            ADD:     result = operand1 + operand2;
            SUB:     result = operand1 - operand2;
            AND:     result = operand1 & operand2;
            OR:      result = operand1 | operand2;
            XOR:     result = operand1 ^ operand2;
            SLT:     result = {31'b0, lessThan};
            SLL:     result = operand1 << shamt;
            SRL:     result = operand1 >> shamt;
            PASSB:   result = operand2;
            default: result = '0;
        endcase
    end

    // Branches run as SUB, so a zero result means equal operands
    assign zero = (result == '0);

endmodule

/* source/exCore.sv */
`timescale 1ns/10ps

module exCore #(
    parameter int IMEM_ADDR_BITS = 8,
    parameter int DMEM_ADDR_BITS = 8
) (
    input  logic               Clk,
    input  logic               reset,
    // Program load, only while reset is high
    input  logic               imemLoad,
    input  exCorePkg::tWord    imemLoadAddr,
    input  exCorePkg::tWord    imemLoadData,
    // Commit traces
    output exCorePkg::tWbTrace wbTrace,
    output exCorePkg::tStTrace stTrace
);
    import exCorePkg::*;

    // Stage 100
    tWord    pcQ100H;
    tWord    pcNextQ100H;
    tWord    iMemAddr;
    // Stage 101
    logic    validQ101H;
    tWord    pcQ101H;
    tWord    instrQ101H;
    tOpcode  opcodeQ101H;
    tWord    immQ101H;
    tCtrlAlu ctrlAluQ101H;
    tCtrlRf  ctrlRfQ101H;
    tCtrlMem ctrlMemQ101H;
    tWord    rfData1Q101H;
    tWord    rfData2Q101H;
    tWord    src1Q101H;
    tWord    src2Q101H;
    tWord    aluIn2Q101H;
    tWord    aluOutQ101H;
    logic    zeroQ101H;
    logic    redirectQ101H;
    tWord    targetQ101H;
    tWord    resultQ101H;
    // Stage 102
    logic    validQ102H;
    logic    regWrEnQ102H;
    tRegIdx  dstQ102H;
    logic    memRdQ102H;
    tWord    resultQ102H;
    tWord    memRdDataQ102H;
    logic    wbEnQ102H;
    tWord    wbDataQ102H;
    tStTrace stTraceQ102H;

    // ==========================================================================
    // Stage 100, fetch
    // ==========================================================================
    assign pcNextQ100H = redirectQ101H ? targetQ101H : pcQ100H + 32'd4;

    always_ff @(posedge Clk) begin
        if (reset) begin
            pcQ100H <= '0;
        end else begin
            pcQ100H <= pcNextQ100H;
        end
    end

    // Load port owns the instruction memory during reset
    assign iMemAddr = reset ? imemLoadAddr : pcQ100H;

    exCoreMem #(.ADDR_BITS(IMEM_ADDR_BITS)) iMem (
        .Clk    (Clk),
        .addr   (iMemAddr),
        .wrEn   (reset && imemLoad),
        .wrData (imemLoadData),
        .rdData (instrQ101H)
    );

    // Slot behind a redirect is squashed
    always_ff @(posedge Clk) begin
        if (reset) begin
            validQ101H <= 1'b0;
        end else begin
            validQ101H <= !redirectQ101H;
        end
        pcQ101H <= pcQ100H;
    end

    // ==========================================================================
    // Stage 101, decode, register read, execute, memory issue
    // ==========================================================================
    exCoreDecoder decoder (
        .instruction (instrQ101H),
        .opcode      (opcodeQ101H),
        .imm         (immQ101H),
        .ctrlAlu     (ctrlAluQ101H),
        .ctrlRf      (ctrlRfQ101H),
        .ctrlMem     (ctrlMemQ101H)
    );

    exCoreRegFile regFile (
        .Clk     (Clk),
        .reset   (reset),
        .rdIdx1  (ctrlRfQ101H.regSrc1),
        .rdIdx2  (ctrlRfQ101H.regSrc2),
        .rdData1 (rfData1Q101H),
        .rdData2 (rfData2Q101H),
        .wrEn    (wbEnQ102H),
        .wrIdx   (dstQ102H),
        .wrData  (wbDataQ102H)
    );

    // Forward from stage 102, load data included
    assign src1Q101H = (wbEnQ102H && dstQ102H == ctrlRfQ101H.regSrc1) ? wbDataQ102H
                                                                     : rfData1Q101H;
    assign src2Q101H = (wbEnQ102H && dstQ102H == ctrlRfQ101H.regSrc2) ? wbDataQ102H
                                                                     : rfData2Q101H;
    assign aluIn2Q101H = ctrlAluQ101H.useImm ? immQ101H : src2Q101H;

    exCoreAlu alu (
        .operand1 (src1Q101H),
        .operand2 (aluIn2Q101H),
        .ctrl     (ctrlAluQ101H),
        .result   (aluOutQ101H),
        .zero     (zeroQ101H)
    );

    // Branch and JAL both target pc + imm
    assign targetQ101H   = pcQ101H + immQ101H;
    assign redirectQ101H = validQ101H && (ctrlMemQ101H.isJal ||
                           (ctrlMemQ101H.isBranch && (zeroQ101H != ctrlMemQ101H.branchNe)));

    // JAL links pc + 4
    assign resultQ101H = (opcodeQ101H == JAL) ? pcQ101H + 32'd4 : aluOutQ101H;

    exCoreMem #(.ADDR_BITS(DMEM_ADDR_BITS)) dMem (
        .Clk    (Clk),
        .addr   (aluOutQ101H),
        .wrEn   (validQ101H && ctrlMemQ101H.memWr),
        .wrData (src2Q101H),
        .rdData (memRdDataQ102H)
    );

    // ==========================================================================
    // Stage 102, writeback
    // ==========================================================================
    always_ff @(posedge Clk) begin
        if (reset) begin
            validQ102H         <= 1'b0;
            stTraceQ102H.valid <= 1'b0;
        end else begin
            validQ102H         <= validQ101H;
            stTraceQ102H.valid <= validQ101H && ctrlMemQ101H.memWr;
        end
        regWrEnQ102H      <= ctrlRfQ101H.regWrEn;
        dstQ102H          <= ctrlRfQ101H.regDst;
        memRdQ102H        <= ctrlMemQ101H.memRd;
        resultQ102H       <= resultQ101H;
        stTraceQ102H.addr <= aluOutQ101H;
        stTraceQ102H.data <= src2Q101H;
    end

    assign wbEnQ102H   = validQ102H && regWrEnQ102H;
    assign wbDataQ102H = memRdQ102H ? memRdDataQ102H : resultQ102H;

    // Traces
    assign wbTrace = '{valid: wbEnQ102H, dst: dstQ102H, data: wbDataQ102H};
    assign stTrace = stTraceQ102H;

endmodule

/* verification/exCore_chk.sv */
`timescale 1ns/10ps

module exCore_chk (
    input logic               Clk,
    input logic               reset,
    input exCorePkg::tWbTrace wbTrace,
    input exCorePkg::tStTrace stTrace
);
    // Failed assertions so far
    int assertFails = 0;

    // x0 is filtered in the decoder and never commits
    wbDstNonZero: assert property (@(posedge Clk) disable iff (reset)
        wbTrace.valid |-> wbTrace.dst != '0)
    else begin
        $error("writeback trace valid with destination x0");
        assertFails++;
    end

    // Word accesses only
    stAddrAligned: assert property (@(posedge Clk) disable iff (reset)
        stTrace.valid |-> stTrace.addr[1:0] == 2'b00)
    else begin
        $error("store trace address %h is not word aligned", stTrace.addr);
        assertFails++;
    end

    // Pipeline leaves reset empty
    idleAfterReset: assert property (@(posedge Clk)
        reset |=> !wbTrace.valid && !stTrace.valid)
    else begin
        $error("trace valid in the cycle after reset");
        assertFails++;
    end

endmodule

bind exCore exCore_chk traceChk (
    .Clk     (Clk),
    .reset   (reset),
    .wbTrace (wbTrace),
    .stTrace (stTrace)
);

/* verification/exCoreTb.sv */
`timescale 1ns/10ps

module exCoreTb;
    import exCorePkg::*;

    // ==========================================================================
    // Run length
    // ==========================================================================
    localparam int NUM_RANDOM   = 48;
    localparam int PROG_LEN     = NUM_RANDOM + 1;
    localparam int RESET_CYCLES = 8;
    // Load time, reset, three cycles per instruction and some margin
    localparam int CYCLE_LIMIT  = PROG_LEN + RESET_CYCLES + 3 * NUM_RANDOM + 32;

    // Instruction kinds of the generated program
    typedef enum int {
        kAdd, kSub, kAnd, kOr, kXor, kSlt, kSll, kSrl,
        kAddi, kAndi, kOri, kXori, kSlti,
        kLui, kLw, kSw, kBeq, kBne, kJal
    } tKind;

    // DUT ports
    logic    Clk;
    logic    reset;
    logic    imemLoad;
    tWord    imemLoadAddr;
    tWord    imemLoadData;
    tWbTrace wbTrace;
    tStTrace stTrace;

    // Bookkeeping
    int      seed;
    int      cycleCount      = 0;
    int      mismatchCount   = 0;
    int      unexpectedCount = 0;
    int      missingCount    = 0;
    int      assertCount;

    // Program, as fields and as encoded words
    tKind    kindA [PROG_LEN];
    tRegIdx  rdA [PROG_LEN];
    tRegIdx  rs1A [PROG_LEN];
    tRegIdx  rs2A [PROG_LEN];
    tWord    immA [PROG_LEN];
    tWord    progWord [PROG_LEN];

    // Expected commit events, oldest first
    tWbTrace expWb [$];
    tStTrace expSt [$];

    exCore #(.IMEM_ADDR_BITS(8), .DMEM_ADDR_BITS(8)) i_exCore (
        .Clk          (Clk),
        .reset        (reset),
        .imemLoad     (imemLoad),
        .imemLoadAddr (imemLoadAddr),
        .imemLoadData (imemLoadData),
        .wbTrace      (wbTrace),
        .stTrace      (stTrace)
    );

    // 40 ns clock
    always #20 Clk = ~Clk;

    always @(posedge Clk) begin
        cycleCount <= cycleCount + 1;
    end

    // ==========================================================================
    // Program generator
    // ==========================================================================
    function automatic int unsigned randBelow(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic tWord encodeInstr(tKind k, tRegIdx rd, tRegIdx rs1, tRegIdx rs2,
                                         tWord imm);
        case (k)
            kAdd:    return {7'h00, rs2, rs1, 3'b000, rd, R_OP};
            kSub:    return {7'h20, rs2, rs1, 3'b000, rd, R_OP};
            kAnd:    return {7'h00, rs2, rs1, 3'b111, rd, R_OP};
            kOr:     return {7'h00, rs2, rs1, 3'b110, rd, R_OP};
            kXor:    return {7'h00, rs2, rs1, 3'b100, rd, R_OP};
            kSlt:    return {7'h00, rs2, rs1, 3'b010, rd, R_OP};
            kSll:    return {7'h00, rs2, rs1, 3'b001, rd, R_OP};
            kSrl:    return {7'h00, rs2, rs1, 3'b101, rd, R_OP};
            kAddi:   return {imm[11:0], rs1, 3'b000, rd, I_OP};
            kAndi:   return {imm[11:0], rs1, 3'b111, rd, I_OP};
            kOri:    return {imm[11:0], rs1, 3'b110, rd, I_OP};
            kXori:   return {imm[11:0], rs1, 3'b100, rd, I_OP};
            kSlti:   return {imm[11:0], rs1, 3'b010, rd, I_OP};
            kLui:    return {imm[31:12], rd, LUI};
            kLw:     return {imm[11:0], rs1, 3'b010, rd, LOAD};
            kSw:     return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
            kBeq:    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], BRANCH};
            kBne:    return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], BRANCH};
            default: return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
        endcase
    endfunction

    task automatic buildProgram();
        tWord raw;
        int   offWords;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            raw      = $random(seed);
            kindA[i] = tKind'(randBelow(19));
            // Only x0..x7, so neighbours often depend on each other
            rdA[i]   = tRegIdx'(randBelow(8));
            rs1A[i]  = tRegIdx'(randBelow(8));
            rs2A[i]  = tRegIdx'(randBelow(8));
            immA[i]  = {{20{raw[11]}}, raw[11:0]};
            if (kindA[i] == kLui) begin
                immA[i] = {raw[31:12], 12'b0};
            end else if (kindA[i] == kLw || kindA[i] == kSw) begin
                // x0 base, one of 16 words
                rs1A[i] = '0;
                immA[i] = tWord'(randBelow(16) * 4);
            end else if (kindA[i] == kBeq || kindA[i] == kBne || kindA[i] == kJal) begin
                // Forward only, never past the closing JAL
                offWords = 1 + int'(randBelow(6));
                if (offWords > PROG_LEN - 1 - i) begin
                    offWords = PROG_LEN - 1 - i;
                end
                immA[i] = tWord'(offWords * 4);
            end
        end
        // Closing JAL x0 onto itself
        kindA[PROG_LEN-1] = kJal;
        rdA[PROG_LEN-1]   = '0;
        rs1A[PROG_LEN-1]  = '0;
        rs2A[PROG_LEN-1]  = '0;
        immA[PROG_LEN-1]  = '0;
        for (int i = 0; i < PROG_LEN; i++) begin
            progWord[i] = encodeInstr(kindA[i], rdA[i], rs1A[i], rs2A[i], immA[i]);
        end
    endtask

    // ==========================================================================
    // Instruction-level reference model
    // ==========================================================================
    task automatic runModel();
        tWord xr [32];
        tWord refMem [16];
        tWord a;
        tWord b;
        tWord addr;
        tWord res;
        logic wr;
        int   pc;
        int   nextPc;
        for (int i = 0; i < 32; i++) begin
            xr[i] = '0;
        end
        for (int i = 0; i < 16; i++) begin
            refMem[i] = '0;
        end
        pc = 0;
        // Stops at the closing JAL, it only spins from there on
        while (pc < PROG_LEN - 1) begin
            a      = xr[rs1A[pc]];
            b      = xr[rs2A[pc]];
            addr   = a + immA[pc];
            res    = '0;
            wr     = 1'b1;
            nextPc = pc + 1;
            case (kindA[pc])
                kAdd:  res = a + b;
                kSub:  res = a - b;
                kAnd:  res = a & b;
                kOr:   res = a | b;
                kXor:  res = a ^ b;
                kSlt:  res = {31'b0, $signed(a) < $signed(b)};
                kSll:  res = a << b[4:0];
                kSrl:  res = a >> b[4:0];
                kAddi: res = a + immA[pc];
                kAndi: res = a & immA[pc];
                kOri:  res = a | immA[pc];
                kXori: res = a ^ immA[pc];
                kSlti: res = {31'b0, $signed(a) < $signed(immA[pc])};
                kLui:  res = immA[pc];
                kLw:   res = refMem[addr[5:2]];
                kSw: begin
                    wr                = 1'b0;
                    refMem[addr[5:2]] = b;
                    expSt.push_back('{valid: 1'b1, addr: addr, data: b});
                end
                kBeq, kBne: begin
                    wr = 1'b0;
                    if ((a == b) == (kindA[pc] == kBeq)) begin
                        nextPc = pc + int'(immA[pc]) / 4;
                    end
                end
                default: begin
                    // JAL links the next word address
                    res    = tWord'((pc + 1) * 4);
                    nextPc = pc + int'(immA[pc]) / 4;
                end
            endcase
            // x0 is never written and leaves no trace
            if (wr && rdA[pc] != '0) begin
                xr[rdA[pc]] = res;
                expWb.push_back('{valid: 1'b1, dst: rdA[pc], data: res});
            end
            pc = nextPc;
        end
    endtask

    // ==========================================================================
    // Trace compare
    // ==========================================================================
    task automatic compareWb(input tWbTrace actual);
        tWbTrace expected;
        if (expWb.size() == 0) begin
            $display("unexpected writeback of x%0d at %0t, no writeback was left to commit",
                     actual.dst, $time);
            unexpectedCount++;
        end else begin
            expected = expWb.pop_front();
            if (actual.dst !== expected.dst || actual.data !== expected.data) begin
                $display("mismatch at %0t: writeback expected x%0d = %h, got x%0d = %h",
                         $time, expected.dst, expected.data, actual.dst, actual.data);
                mismatchCount++;
            end
        end
    endtask

    task automatic compareSt(input tStTrace actual);
        tStTrace expected;
        if (expSt.size() == 0) begin
            $display("unexpected store to %h at %0t, no store was left to issue",
                     actual.addr, $time);
            unexpectedCount++;
        end else begin
            expected = expSt.pop_front();
            if (actual.addr !== expected.addr || actual.data !== expected.data) begin
                $display("mismatch at %0t: store expected [%h] = %h, got [%h] = %h",
                         $time, expected.addr, expected.data, actual.addr, actual.data);
                mismatchCount++;
            end
        end
    endtask

    // Traces settle after the rising edge, look at them on the falling one
    always @(negedge Clk) begin
        if (!reset) begin
            if (wbTrace.valid) begin
                compareWb(wbTrace);
            end
            if (stTrace.valid) begin
                compareSt(stTrace);
            end
        end
    end

    // ==========================================================================
    // Main sequence
    // ==========================================================================
    initial begin
        Clk          = 1'b0;
        reset        = 1'b1;
        imemLoad     = 1'b0;
        imemLoadAddr = '0;
        imemLoadData = '0;
        seed         = 32'hf1c4;
        buildProgram();
        runModel();

        repeat (RESET_CYCLES) @(posedge Clk);
        // One program word per cycle while reset is still high
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge Clk);
            imemLoad     <= 1'b1;
            imemLoadAddr <= tWord'(i * 4);
            imemLoadData <= progWord[i];
        end
        @(posedge Clk);
        imemLoad <= 1'b0;
        reset    <= 1'b0;

        while ((expWb.size() != 0 || expSt.size() != 0) && cycleCount < CYCLE_LIMIT) begin
            @(posedge Clk);
        end
        if (expWb.size() != 0 || expSt.size() != 0) begin
            $display("timeout after %0d cycles, %0d writebacks and %0d stores never appeared",
                     cycleCount, expWb.size(), expSt.size());
            missingCount = expWb.size() + expSt.size();
        end else begin
            // Core spins on the closing JAL, nothing else may commit
            repeat (8) @(posedge Clk);
        end

        assertCount = i_exCore.traceChk.assertFails;
        $display("errors: %0d mismatch, %0d unexpected, %0d missing, %0d assertion",
                 mismatchCount, unexpectedCount, missingCount, assertCount);
        if (mismatchCount + unexpectedCount + missingCount + assertCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* exCore.f */
common/exCorePkg.sv
source/exCoreMem.sv
decoder/exCoreDecoder.sv
source/exCoreRegFile.sv
source/exCoreAlu.sv
source/exCore.sv
verification/exCore_chk.sv
verification/exCoreTb.sv

/* runSim.sh */
#!/bin/sh
# Build and run the exCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module exCoreTb -f exCore.f -Mdir obj_dir

# The log decides pass or fail
./obj_dir/VexCoreTb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Verification passed$" sim.log; then
    exit 0
fi
exit 1
